// File: bus_controller/mem_bus_controller.sv
/*
 * Line bus master controller
 */

`timescale 1ns/10ps

module mem_bus_controller (
   input  logic                   bus_clk,
   input  logic                   rst,
   // Work unit side
   input  line_bus_pkg::unit_req_t req,
   output line_bus_pkg::unit_rsp_t rsp,
   // Arbiter side
   output logic                   br,
   input  logic                   bg,
   output line_bus_pkg::bus_req_t bus,
   input  line_bus_pkg::bus_rsp_t bus_rsp
);
   import line_bus_pkg::*;

   ctrl_state_t state_q;
   ctrl_state_t state_d;

   // Latched transfer, loaded on the strobe
   logic  wr_q;
   addr_t addr_q;
   line_t wdata_q;

   // Beats sent and acks seen, both wrap after four
   beat_t beat_q;
   beat_t ack_cnt_q;

   // Read assembly and the line shown to the unit
   line_t fill_q;
   line_t rdata_q;
   logic  done_q;

   logic  ack_ok;
   logic  last_beat;
   logic  last_ack;

   // The shared response only counts while we own the bus
   assign ack_ok = bus_rsp.ack && bg &&
                   ((state_q == MASTER) || (state_q == DRAIN));

   assign last_beat = (beat_q == beat_t'(BEATS - 1));
   assign last_ack  = ack_ok && (ack_cnt_q == beat_t'(BEATS - 1));

   // Next state
   always_comb begin
      state_d = state_q;
      unique case (state_q)
         IDLE: begin
            if (req.en) begin
               state_d = REQ;
            end
         end
         REQ: begin
            // Stay here as long as the other master holds the bus
            if (bg) begin
               state_d = MASTER;
            end
         end
         MASTER: begin
            if (last_beat) begin
               state_d = DRAIN;
            end
         end
         DRAIN: begin
            // Wait for the ack of beat 3
            if (last_ack) begin
               state_d = IDLE;
            end
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   // Control registers
   always_ff @(posedge bus_clk) begin
      if (rst) begin
         state_q   <= IDLE;
         beat_q    <= '0;
         ack_cnt_q <= '0;
         done_q    <= 1'b0;
      end else begin
         state_q <= state_d;
         done_q  <= (state_q == DRAIN) && last_ack;
         if ((state_q == IDLE) && req.en) begin
            beat_q    <= '0;
            ack_cnt_q <= '0;
         end else begin
            if (state_q == MASTER) begin
               beat_q <= beat_q + 1'b1;
            end
            if (ack_ok) begin
               ack_cnt_q <= ack_cnt_q + 1'b1;
            end
         end
      end
   end

   // Request payload
   always_ff @(posedge bus_clk) begin
      if ((state_q == IDLE) && req.en) begin
         wr_q    <= req.wr;
         addr_q  <= req.addr;
         wdata_q <= req.wdata;
      end
   end

   // Read data path
   always_ff @(posedge bus_clk) begin
      if (ack_ok && !wr_q) begin
         fill_q[ack_cnt_q*WORD_W +: WORD_W] <= bus_rsp.rdata;
         // Last word goes straight into the visible line
         if (last_ack) begin
            rdata_q <= {bus_rsp.rdata, fill_q[LINE_W-WORD_W-1:0]};
         end
      end
   end

   // Bus request while owning the bus
   assign br = (state_q == REQ) || (state_q == MASTER);

   always_comb begin
      bus.valid = (state_q == MASTER);
      bus.rw    = wr_q;
      // Line base plus four bytes per beat
      bus.addr  = {addr_q[ADDR_W-1:4], beat_q, 2'b00};
      bus.wdata = wdata_q[beat_q*WORD_W +: WORD_W];
   end

   // Unit response
   assign rsp.done  = done_q;
   assign rsp.rdata = rdata_q;

endmodule

// File: common/line_bus_pkg.sv
/*
 * Line bus shared types
 */

package line_bus_pkg;

   // Bus and line widths
   localparam int ADDR_W = 16;
   localparam int WORD_W = 32;

   // Beats per line, lowest word first on the bus
   localparam int BEATS  = 4;
   localparam int LINE_W = WORD_W * BEATS;

   // Line memory depth in words, indexed by byte address bits 9:2
   localparam int RAM_WORDS = 256;
   localparam int RAM_AW    = $clog2(RAM_WORDS);

   // Byte address, bits 3:0 zero for a line
   typedef logic [ADDR_W-1:0] addr_t;

   // One bus beat
   typedef logic [WORD_W-1:0] word_t;

   // Full line, word k at bits 32k+31:32k
   typedef logic [LINE_W-1:0] line_t;

   // Beat index within a line
   typedef logic [$clog2(BEATS)-1:0] beat_t;

   // Word index into the line memory
   typedef logic [RAM_AW-1:0] ram_idx_t;

   // Work unit request, en is a single-cycle strobe
   typedef struct packed {
      logic  en;
      logic  wr;
      addr_t addr;
      line_t wdata;
   } unit_req_t;

   // Work unit response
   // rdata keeps the last read line until the next read completes
   typedef struct packed {
      logic  done;
      line_t rdata;
   } unit_rsp_t;

   // One beat driven by the bus owner
   typedef struct packed {
      logic  valid;
      logic  rw;
      addr_t addr;
      word_t wdata;
   } bus_req_t;

   // Memory answer, one ack per beat
   typedef struct packed {
      logic  ack;
      word_t rdata;
   } bus_rsp_t;

   // Controller FSM
   typedef enum logic [1:0] {
      IDLE   = 2'd0,
      REQ    = 2'd1,
      MASTER = 2'd2,
      DRAIN  = 2'd3
   } ctrl_state_t;

endpackage

// File: hdl/bus_arbiter.sv
/* Two-master bus arbiter */

`timescale 1ns/10ps

module bus_arbiter (
   input  logic                 bus_clk,
   input  logic                 rst,
   input  logic [1:0]           br,
   input  line_bus_pkg::bus_req_t m0_bus,
   input  line_bus_pkg::bus_req_t m1_bus,
   output logic [1:0]           bg,
   output line_bus_pkg::bus_req_t bus
);
   import line_bus_pkg::*;

   // Current owner and round-robin history
   logic own_vld_q;
   logic own_q;
   logic last_q;
   logic pick;

   bus_req_t sel;

   // Both asking: the one not served last wins
   always_comb begin
      if (br == 2'b11) begin
         pick = ~last_q;
      end else begin
         pick = br[1];
      end
   end

   always_ff @(posedge bus_clk) begin
      if (rst) begin
         own_vld_q <= 1'b0;
         own_q     <= 1'b0;
         // Pretend master 1 went last so master 0 wins first
         last_q    <= 1'b1;
      end else if (own_vld_q) begin
         // Hold for the burst, let go once the owner drops br
         if (!br[own_q]) begin
            own_vld_q <= 1'b0;
         end
      end else if (|br) begin
         own_vld_q <= 1'b1;
         own_q     <= pick;
         last_q    <= pick;
      end
   end

   // Grant decode from the owner registers
   assign bg = own_vld_q ? (own_q ? 2'b10 : 2'b01) : 2'b00;

   // Bus multiplexer, idle bus carries no valid beat
   always_comb begin
      sel = own_q ? m1_bus : m0_bus;
      if (!own_vld_q) begin
         sel.valid = 1'b0;
      end
      bus = sel;
   end

endmodule

// File: hdl/line_bus_top.sv
/*
 * Line transfer subsystem top
 */

`timescale 1ns/10ps

module line_bus_top (
   input  logic                    bus_clk,
   input  logic                    rst,
   input  line_bus_pkg::unit_req_t req0,
   input  line_bus_pkg::unit_req_t req1,
   output line_bus_pkg::unit_rsp_t rsp0,
   output line_bus_pkg::unit_rsp_t rsp1
);
   import line_bus_pkg::*;

   // Arbitration handshake, bit n per controller
   logic [1:0] br;
   logic [1:0] bg;

   // Per-master requests and the muxed bus
   bus_req_t m0_bus;
   bus_req_t m1_bus;
   bus_req_t bus;

   // Memory answer, seen by both controllers
   bus_rsp_t bus_rsp;

   // Unit 0 controller
   mem_bus_controller u_ctrl0 (
      .bus_clk (bus_clk),
      .rst     (rst),
      .req     (req0),
      .rsp     (rsp0),
      .br      (br[0]),
      .bg      (bg[0]),
      .bus     (m0_bus),
      .bus_rsp (bus_rsp)
   );

   // Unit 1 controller
   mem_bus_controller u_ctrl1 (
      .bus_clk (bus_clk),
      .rst     (rst),
      .req     (req1),
      .rsp     (rsp1),
      .br      (br[1]),
      .bg      (bg[1]),
      .bus     (m1_bus),
      .bus_rsp (bus_rsp)
   );

   bus_arbiter u_arbiter (
      .bus_clk (bus_clk),
      .rst     (rst),
      .br      (br),
      .m0_bus  (m0_bus),
      .m1_bus  (m1_bus),
      .bg      (bg),
      .bus     (bus)
   );

   // Single slave on the bus
   line_ram u_ram (
      .bus_clk (bus_clk),
      .rst     (rst),
      .bus     (bus),
      .bus_rsp (bus_rsp)
   );

endmodule

// File: hdl/line_ram.sv
/*
 * Line memory bus slave
 */

`timescale 1ns/10ps

module line_ram (
   input  logic                   bus_clk,
   input  logic                   rst,
   input  line_bus_pkg::bus_req_t bus,
   output line_bus_pkg::bus_rsp_t bus_rsp
);
   import line_bus_pkg::*;

   // Word storage, contents are undefined after reset
   word_t mem [RAM_WORDS];

   // Word index from byte address bits 9:2
   // Upper address bits are ignored, so lines alias every 1 KiB
   ram_idx_t idx;

   word_t rdata_q;
   logic  ack_q;

   assign idx = bus.addr[RAM_AW+1:2];

   // Write on the beat edge, registered read
   always_ff @(posedge bus_clk) begin
      if (bus.valid) begin
         if (bus.rw) begin
            mem[idx] <= bus.wdata;
         end else begin
            rdata_q <= mem[idx];
         end
      end
   end

   // One ack per beat, one cycle later
   always_ff @(posedge bus_clk) begin
      if (rst) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= bus.valid;
      end
   end

   // Read word lines up with its ack
   assign bus_rsp.ack   = ack_q;
   assign bus_rsp.rdata = rdata_q;

endmodule

// File: line_bus_top.f
common/line_bus_pkg.sv
hdl/bus_arbiter.sv
bus_controller/mem_bus_controller.sv
hdl/line_ram.sv
hdl/line_bus_top.sv
verif/line_bus_assertions.sv
verif/line_bus_checker.sv
verif/line_bus_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the line bus testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module line_bus_tb \
   -f line_bus_top.f -o line_bus_sim || exit 1
# Raised error limit keeps an assertion failure from ending the run early
out="$(./obj_dir/line_bus_sim +verilator+error+limit+1000)"
echo "$out"
echo "$out" | grep -qF '*** PASSED ***' && exit 0 || exit 1

// File: verif/line_bus_assertions.sv
/* Controller protocol assertions */

`timescale 1ns/10ps

module line_bus_assertions (
   input logic                      bus_clk,
   input logic                      rst,
   input line_bus_pkg::unit_req_t   req,
   input line_bus_pkg::unit_rsp_t   rsp,
   input logic                      br,
   input logic                      bg,
   input line_bus_pkg::bus_req_t    bus,
   input line_bus_pkg::bus_rsp_t    bus_rsp,
   input line_bus_pkg::ctrl_state_t state_q
);
   import line_bus_pkg::*;

   logic       br_q;
   // Acks seen since br last rose
   logic [2:0] acks;
   int         bad_valid = 0;
   int         bad_strobe = 0;
   int         bad_pulse = 0;
   int         bad_acks = 0;
   int         fail_cnt;

   assign fail_cnt = bad_valid + bad_strobe + bad_pulse + bad_acks;

   always_ff @(posedge bus_clk) begin
      if (rst) begin
         br_q <= 1'b0;
         acks <= '0;
      end else begin
         br_q <= br;
         if (br && !br_q) begin
            acks <= '0;
         end else if (bus_rsp.ack && bg) begin
            acks <= acks + 3'd1;
         end
      end
   end

   valid_needs_grant: assert property (@(posedge bus_clk) disable iff (rst) bus.valid |-> bg)
      else begin
         $error("Beat driven without a grant");
         bad_valid++;
      end

   strobe_when_idle: assert property (@(posedge bus_clk) disable iff (rst)
                                      req.en |-> state_q == IDLE)
      else begin
         $error("Request strobe while a transfer is open");
         bad_strobe++;
      end

   done_one_cycle: assert property (@(posedge bus_clk) disable iff (rst)
                                    rsp.done |=> !rsp.done)
      else begin
         $error("Done held longer than one cycle");
         bad_pulse++;
      end

   four_acks: assert property (@(posedge bus_clk) disable iff (rst) rsp.done |-> acks == 3'd4)
      else begin
         $error("Done without exactly four acks");
         bad_acks++;
      end

endmodule

bind mem_bus_controller line_bus_assertions u_assert (.*);

// File: verif/line_bus_checker.sv
/* Line bus reference checker */

`timescale 1ns/10ps

module line_bus_checker (
   input  logic                    bus_clk,
   input  logic                    rst,
   input  line_bus_pkg::unit_req_t req0,
   input  line_bus_pkg::unit_req_t req1,
   input  line_bus_pkg::unit_rsp_t rsp0,
   input  line_bus_pkg::unit_rsp_t rsp1,
   output int                      data_errs,
   output int                      order_errs
);
   import line_bus_pkg::*;

   // Image of the 1 KiB memory, one line per address bits 9:4
   line_t     model [64];
   logic      model_vld [64];
   // Transfer in flight per port
   unit_req_t cur [2];
   int        start [2];
   logic      shared [2];
   // Open simultaneous pair and its expected winner
   logic      pair_open;
   logic      first_exp;
   logic      last_port;
   int        cyc;

   task automatic take_done(input int p, input line_t rdata);
      int         lat;
      logic [5:0] li;
      lat = cyc - start[p];
      li  = cur[p].addr[9:4];
      // Lone transfers and the winner of a pair take 8 cycles
      if ((pair_open || !shared[p]) && lat != 8) begin
         $display("CHECK FAILED rsp%0d.done latency expected %0h actual %0h", p, 8, lat);
         order_errs++;
      end
      if (pair_open && ((p == 1) != first_exp)) begin
         $display("Port %0d finished first although the other port should have won", p);
         order_errs++;
      end
      pair_open = 1'b0;
      if (cur[p].wr) begin
         model[li]     = cur[p].wdata;
         model_vld[li] = 1'b1;
      end else if (!model_vld[li]) begin
         $display("Port %0d read a line that was never written", p);
         data_errs++;
      end else if (rdata !== model[li]) begin
         $display("CHECK FAILED rsp%0d.rdata expected %h actual %h",
                  p, model[li], rdata);
         data_errs++;
      end
      // Grants and dones come in the same order
      last_port = (p == 1);
   endtask

   always @(posedge bus_clk) begin
      if (rst) begin
         data_errs  = 0;
         order_errs = 0;
         cyc        = 0;
         pair_open  = 1'b0;
         // Port 0 wins the first contest
         last_port  = 1'b1;
         model_vld  = '{default: 1'b0};
      end else begin
         cyc = cyc + 1;
         if (req0.en) begin
            cur[0]    = req0;
            start[0]  = cyc;
            shared[0] = req1.en;
         end
         if (req1.en) begin
            cur[1]    = req1;
            start[1]  = cyc;
            shared[1] = req0.en;
         end
         if (req0.en && req1.en) begin
            pair_open = 1'b1;
            first_exp = !last_port;
         end
         if (rsp0.done) take_done(0, rsp0.rdata);
         if (rsp1.done) take_done(1, rsp1.rdata);
      end
   end

endmodule

// File: verif/line_bus_tb.sv
/* Line bus testbench */

`timescale 1ns/10ps

module line_bus_tb;
   import line_bus_pkg::*;

   localparam int N_ENTRIES = 14;
   // A contended pair stays well under 20 cycles per entry
   localparam int TIMEOUT = N_ENTRIES * 20 + 100;
   // In a pair, port 1 goes to this other line
   localparam addr_t PAIR_OFS = 16'h0200;

   // One stimulus entry, mask bit n strobes port n
   typedef struct packed {
      logic [1:0] mask;
      logic       wr;
      addr_t      addr;
      line_t      wline;
   } stim_t;

   logic      bus_clk = 1'b0;
   logic      rst;
   unit_req_t req0;
   unit_req_t req1;
   unit_rsp_t rsp0;
   unit_rsp_t rsp1;
   int        data_errs;
   int        order_errs;
   int        assert_errs;
   int        seed;
   int        cyc = 0;
   stim_t     tbl [N_ENTRIES];

   line_bus_top UUT (.*);

   // Compares read lines, completion order and latency
   line_bus_checker u_checker (.*);

   // Failure counts of the bound controller assertions
   assign assert_errs = UUT.u_ctrl0.u_assert.fail_cnt + UUT.u_ctrl1.u_assert.fail_cnt;

   always #4 bus_clk = ~bus_clk;

   // Run limit
   always @(posedge bus_clk) begin
      cyc <= cyc + 1;
      if (cyc == TIMEOUT) begin
         $display("Timeout after %0d cycles, a done strobe never arrived", cyc);
         $display("*** FAILED ***");
         $finish;
      end
   end

   function automatic line_t rand_line();
      return {$random(seed), $random(seed), $random(seed), $random(seed)};
   endfunction

   task automatic add_entry(input int i, input logic [1:0] mask, input logic wr,
                            input addr_t addr);
      tbl[i] = '{mask, wr, addr, rand_line()};
   endtask

   // Strobe the masked ports for one cycle, then wait for every done
   task automatic apply_entry(input stim_t e);
      logic [1:0] waiting;
      @(posedge bus_clk);
      #1;
      req0 = '{en: e.mask[0], wr: e.wr, addr: e.addr, wdata: e.wline};
      if (e.mask == 2'b11) begin
         req1 = '{en: 1'b1, wr: e.wr, addr: e.addr ^ PAIR_OFS, wdata: ~e.wline};
      end else begin
         req1 = '{en: e.mask[1], wr: e.wr, addr: e.addr, wdata: e.wline};
      end
      @(posedge bus_clk);
      #1;
      req0.en = 1'b0;
      req1.en = 1'b0;
      waiting = e.mask;
      while (waiting != 2'b00) begin
         @(posedge bus_clk);
         #1;
         if (rsp0.done) waiting[0] = 1'b0;
         if (rsp1.done) waiting[1] = 1'b0;
      end
   endtask

   initial begin
      rst  = 1'b1;
      req0 = '0;
      req1 = '0;
      seed = 32'h5eb4;
      // Pair right after reset, port 0 wins
      add_entry(0, 2'b11, 1'b1, 16'h0100);
      add_entry(1, 2'b01, 1'b0, 16'h0100);
      // Port 0 writes, both ports read back
      add_entry(2, 2'b01, 1'b1, 16'h0040);
      add_entry(3, 2'b01, 1'b0, 16'h0040);
      add_entry(4, 2'b10, 1'b0, 16'h0040);
      // Port 1 writes, port 0 reads
      add_entry(5, 2'b10, 1'b1, 16'h0080);
      add_entry(6, 2'b01, 1'b0, 16'h0080);
      // Port 0 went last, so port 1 wins this pair
      add_entry(7, 2'b11, 1'b0, 16'h0100);
      // 0x0540 and 0x0940 land on the line at 0x0140
      add_entry(8, 2'b01, 1'b1, 16'h0140);
      add_entry(9, 2'b10, 1'b1, 16'h0540);
      add_entry(10, 2'b01, 1'b0, 16'h0140);
      add_entry(11, 2'b10, 1'b0, 16'h0940);
      // Two more pairs after a port 1 transfer
      add_entry(12, 2'b11, 1'b1, 16'h0180);
      add_entry(13, 2'b11, 1'b0, 16'h0180);
      repeat (8) @(posedge bus_clk);
      #1;
      rst = 1'b0;
      for (int i = 0; i < N_ENTRIES; i++) begin
         apply_entry(tbl[i]);
      end
      repeat (2) @(posedge bus_clk);
      $display("Errors: data %0d, order/latency %0d, assertion %0d",
               data_errs, order_errs, assert_errs);
      if (data_errs + order_errs + assert_errs == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule
